/* sources.f */
design/axi_master_pkg.sv
design/read_port_fsm.sv
design/read_arbiter.sv
design/write_port_fsm.sv
design/axi_master.sv
bench/axi_slave_model.sv
bench/axi_master_assert.sv
bench/tb_axi_master.sv

/* bench/tb_axi_master.sv */
`timescale 1ns/10ps

module tb_axi_master;
    import axi_master_pkg::*;

    localparam logic [ID_W-1:0] INST_ID   = 4'd2;
    localparam logic [ID_W-1:0] DATA_ID   = 4'd3;
    localparam int              MAX_CYCLE = 4000;

    logic              aclk;
    logic              aresetn;
    cpu_rd_req_t       inst_req;
    logic              data_ce;
    logic              data_we;
    logic [ADDR_W-1:0] data_addr;
    logic [DATA_W-1:0] data_wdata;
    logic [STRB_W-1:0] data_sel;
    logic [ID_W-1:0]   data_id;
    logic              s_arready;
    r_beat_t           s_r;
    logic              s_awready;
    logic              s_wready;
    logic              s_bvalid;
    logic [DATA_W-1:0] inst_rdata;
    logic              inst_stall;
    logic [DATA_W-1:0] data_rdata;
    logic              data_stall;
    ar_req_t           s_ar;
    logic              s_arvalid;
    logic [LEN_W-1:0]  s_arlen;
    logic [1:0]        s_arburst;
    logic              s_rready;
    aw_req_t           s_aw;
    logic [ID_W-1:0]   s_awid;
    logic [LEN_W-1:0]  s_awlen;
    logic [1:0]        s_awburst;
    logic              s_awvalid;
    w_beat_t           s_w;
    logic              s_wlast;
    logic              s_wvalid;
    logic              s_bready;

    logic [DATA_W-1:0] shadow [MODEL_WORDS];
    ar_req_t           ar_log [$];
    int                ar_cyc [$];
    int                b_cyc;
    int                cycle;

    axi_master axi_master_inst (
        .aclk(aclk), .aresetn(aresetn), .inst_req_i(inst_req), .data_ce_i(data_ce),
        .data_we_i(data_we), .data_addr_i(data_addr), .data_wdata_i(data_wdata),
        .data_sel_i(data_sel), .data_id_i(data_id), .s_arready_i(s_arready), .s_r_i(s_r),
        .s_awready_i(s_awready), .s_wready_i(s_wready), .s_bvalid_i(s_bvalid),
        .inst_rdata_o(inst_rdata), .inst_stall_o(inst_stall), .data_rdata_o(data_rdata),
        .data_stall_o(data_stall), .s_ar_o(s_ar), .s_arvalid_o(s_arvalid),
        .s_arlen_o(s_arlen), .s_arburst_o(s_arburst), .s_rready_o(s_rready),
        .s_aw_o(s_aw), .s_awid_o(s_awid), .s_awlen_o(s_awlen), .s_awburst_o(s_awburst),
        .s_awvalid_o(s_awvalid), .s_w_o(s_w), .s_wlast_o(s_wlast), .s_wvalid_o(s_wvalid),
        .s_bready_o(s_bready)
    );

    axi_slave_model slave_inst (
        .aclk(aclk), .aresetn(aresetn), .ar_i(s_ar), .arvalid_i(s_arvalid),
        .arready_o(s_arready), .r_o(s_r), .rready_i(s_rready), .aw_i(s_aw),
        .awvalid_i(s_awvalid), .awready_o(s_awready), .w_i(s_w), .wvalid_i(s_wvalid),
        .wready_o(s_wready), .bvalid_o(s_bvalid), .bready_i(s_bready)
    );

    bind axi_master axi_master_assert axi_master_assert_inst (.*);

    initial
    begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // handshake log and run limit
    always @(posedge aclk)
    begin
        cycle = cycle + 1;
        if (s_arvalid && s_arready)
        begin
            ar_log.push_back(s_ar);
            ar_cyc.push_back(cycle);
        end
        if (s_bvalid && s_bready)
            b_cyc = cycle;
        if (cycle >= MAX_CYCLE)
        begin
            $display("Timeout: no result after %0d cycles", cycle);
            $display("Something failed");
            $fatal(1);
        end
    end

    function automatic int word_idx(input logic [ADDR_W-1:0] addr);
        return int'(addr[$clog2(MODEL_WORDS)+1:2]);
    endfunction

    function automatic logic [DATA_W-1:0] strobe_merge(input logic [DATA_W-1:0] old,
            input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] sel);
        logic [DATA_W-1:0] res;
        res = old;
        for (int b = 0; b < STRB_W; b++)
        begin
            if (sel[b])
                res[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
            input logic [63:0] act);
        $display("Error %s: expected %h, actual %h", name, exp, act);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic report_problem(input string name, input string what);
        $display("%s: %s", name, what);
        $display("Something failed");
        $fatal(1);
    endtask

    // runs an instruction read and a data access side by side
    // data_late holds the data request back until the instruction AR is out
    task automatic pair_access(input string name, input bit do_inst,
            input logic [ADDR_W-1:0] iaddr, input bit do_data, input bit dwrite,
            input logic [ADDR_W-1:0] daddr, input logic [DATA_W-1:0] wdata,
            input logic [STRB_W-1:0] sel, input bit data_late);
        logic [DATA_W-1:0] iexp;
        logic [DATA_W-1:0] dexp;
        logic [DATA_W-1:0] igot;
        bit                ibusy;
        bit                dbusy;
        bit                dwait;
        bit                held;
        iexp     = shadow[word_idx(iaddr)];
        dexp     = shadow[word_idx(daddr)];
        inst_req = '{ce: do_inst, addr: iaddr, id: INST_ID};
        data_ce    = do_data && !data_late;
        data_we    = dwrite;
        data_addr  = daddr;
        data_wdata = wdata;
        data_sel   = sel;
        data_id    = DATA_ID;
        ibusy = do_inst;
        dbusy = do_data;
        dwait = do_data && data_late;
        held  = 1'b0;
        while (ibusy || dbusy || held)
        begin
            @(negedge aclk);
            if (held)
            begin
                if (data_stall)
                begin
                    assert (!inst_stall && inst_rdata == igot)
                        else report_mismatch({name, " held"}, {1'b0, igot},
                                             {inst_stall, inst_rdata});
                end
                else
                begin
                    held = 1'b0;
                end
            end
            if (ibusy)
            begin
                if (inst_stall)
                begin
                    assert (inst_rdata == '0)
                        else report_mismatch({name, " inst idle"}, 0, inst_rdata);
                end
                else
                begin
                    assert (inst_rdata == iexp)
                        else report_mismatch({name, " inst"}, iexp, inst_rdata);
                    igot        = inst_rdata;
                    held        = data_stall;
                    ibusy       = 1'b0;
                    inst_req.ce = 1'b0;
                end
            end
            if (dbusy && !dwait && !data_stall)
            begin
                if (dwrite)
                begin
                    shadow[word_idx(daddr)] = strobe_merge(dexp, wdata, sel);
                end
                else
                begin
                    assert (data_rdata == dexp)
                        else report_mismatch({name, " data"}, dexp, data_rdata);
                end
                dbusy   = 1'b0;
                data_ce = 1'b0;
            end
            else if (dbusy && !dwait && !dwrite)
            begin
                assert (data_rdata == '0)
                    else report_mismatch({name, " data idle"}, 0, data_rdata);
            end
            // instruction read owns the channel now
            if (dwait && s_arvalid)
            begin
                data_ce = 1'b1;
                dwait   = 1'b0;
            end
        end
    endtask

    task automatic test_reset_state();
        @(negedge aclk);
        assert (!inst_stall && !data_stall && !s_arvalid && !s_awvalid && !s_wvalid
                && !s_bready && !s_rready)
            else report_problem("reset_state", "a control output is high after reset");
        assert (inst_rdata == '0 && data_rdata == '0)
            else report_mismatch("reset_state", 0, {inst_rdata, data_rdata});
    endtask

    task automatic test_fixed_fields();
        logic [16:0] exp;
        logic [16:0] act;
        // single beat, INCR burst, fixed write id, wlast on every beat
        exp = {4'd0, 2'b01, WRITE_ID, 4'd0, 2'b01, 1'b1};
        act = {s_arlen, s_arburst, s_awid, s_awlen, s_awburst, s_wlast};
        assert (act == exp)
            else report_mismatch("fixed_fields", exp, act);
    endtask

    task automatic test_inst_read();
        ar_log.delete();
        pair_access("inst_read", 1'b1, 32'h24, 1'b0, 1'b0, '0, '0, '0, 1'b0);
        assert (ar_log.size() == 1)
            else report_mismatch("inst_read count", 1, ar_log.size());
        assert (ar_log[0] == ar_req_t'{id: INST_ID, addr: 32'h24, size: SIZE_WORD})
            else report_mismatch("inst_read ar", {INST_ID, 32'h24, SIZE_WORD}, ar_log[0]);
    endtask

    task automatic test_partial_write();
        pair_access("partial_write", 1'b0, '0, 1'b1, 1'b1, 32'h40, 32'hdeadbeef,
                    4'b0101, 1'b0);
        pair_access("partial_read", 1'b0, '0, 1'b1, 1'b0, 32'h40, '0, '0, 1'b0);
    endtask

    task automatic test_same_cycle_reads();
        ar_log.delete();
        pair_access("same_cycle", 1'b1, 32'h10, 1'b1, 1'b0, 32'h88, '0, '0, 1'b0);
        assert (ar_log.size() == 2)
            else report_mismatch("same_cycle count", 2, ar_log.size());
        assert (ar_log[0].id == DATA_ID)
            else report_mismatch("same_cycle id", DATA_ID, ar_log[0].id);
        // data read arrives behind the instruction read, so the result is held
        pair_access("held_result", 1'b1, 32'h14, 1'b1, 1'b0, 32'h9c, '0, '0, 1'b1);
        @(negedge aclk);
        assert (inst_rdata == '0)
            else report_mismatch("held_result release", 0, inst_rdata);
    endtask

    task automatic test_read_during_write();
        ar_log.delete();
        ar_cyc.delete();
        pair_access("read_during_write", 1'b1, 32'h30, 1'b1, 1'b1, 32'h50,
                    32'h12345678, 4'b1111, 1'b0);
        assert (ar_cyc.size() == 1 && ar_cyc[0] > b_cyc)
            else report_problem("read_during_write", "read address issued before the write ended");
    endtask

    task automatic test_random_mix();
        int unsigned       op;
        logic [ADDR_W-1:0] addr;
        for (int n = 0; n < 40; n++)
        begin
            op   = $urandom % 3;
            addr = ADDR_W'(($urandom % MODEL_WORDS) * 4);
            case (op)
                0: pair_access("random_inst", 1'b1, addr, 1'b0, 1'b0, '0, '0, '0, 1'b0);
                1: pair_access("random_read", 1'b0, '0, 1'b1, 1'b0, addr, '0, '0, 1'b0);
                default: pair_access("random_write", 1'b0, '0, 1'b1, 1'b1, addr,
                                     $urandom, 4'($urandom), 1'b0);
            endcase
        end
    endtask

    initial
    begin
        logic [7:0]  a;
        void'($urandom(32'hb418e6a9));
        cycle      = 0;
        b_cyc      = 0;
        aresetn    = 1'b0;
        inst_req   = '0;
        data_ce    = 1'b0;
        data_we    = 1'b0;
        data_addr  = '0;
        data_wdata = '0;
        data_sel   = '0;
        data_id    = '0;
        for (int i = 0; i < MODEL_WORDS; i++)
        begin
            a = 8'(i * 4);
            shadow[i] = {a ^ 8'h5a, ~a, a + 8'h33, a};
        end
        repeat (8) @(negedge aclk);
        aresetn = 1'b1;
        test_reset_state();
        test_fixed_fields();
        test_inst_read();
        test_partial_write();
        test_same_cycle_reads();
        test_read_during_write();
        test_random_mix();
        $display("Everything OK");
        $finish;
    end

endmodule

/* bench/axi_master_assert.sv */
`timescale 1ns/10ps

module axi_master_assert
    import axi_master_pkg::*;
(
    input logic    aclk,
    input logic    aresetn,
    input ar_req_t s_ar_o,
    input logic    s_arvalid_o,
    input logic    s_arready_i,
    input aw_req_t s_aw_o,
    input logic    s_awvalid_o,
    input logic    s_awready_i,
    input logic    s_rready_o,
    input logic    s_bready_o
);

    ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_arvalid_o && !s_arready_i |=> s_arvalid_o && $stable(s_ar_o))
        else $error("arvalid or AR content changed before arready");

    aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_awvalid_o && !s_awready_i |=> s_awvalid_o && $stable(s_aw_o))
        else $error("awvalid or AW content changed before awready");

    // no read address while a write response is pending
    ar_after_b: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(s_arvalid_o) |-> !s_bready_o)
        else $error("arvalid raised while bready is high");

    one_read: assert property (@(posedge aclk) disable iff (!aresetn)
        !(s_rready_o && s_arvalid_o))
        else $error("rready and arvalid high together");

endmodule

/* bench/axi_slave_model.sv */
`timescale 1ns/10ps

module axi_slave_model
    import axi_master_pkg::*;
(
    input  logic    aclk,
    input  logic    aresetn,
    input  ar_req_t ar_i,
    input  logic    arvalid_i,
    output logic    arready_o,
    output r_beat_t r_o,
    input  logic    rready_i,
    input  aw_req_t aw_i,
    input  logic    awvalid_i,
    output logic    awready_o,
    input  w_beat_t w_i,
    input  logic    wvalid_i,
    output logic    wready_o,
    output logic    bvalid_o,
    input  logic    bready_i
);

    localparam int IDX_W = $clog2(MODEL_WORDS);

    logic [DATA_W-1:0] mem [MODEL_WORDS];
    logic [ADDR_W-1:0] rd_addr;
    logic [ADDR_W-1:0] wr_addr;
    logic              rd_pend;
    logic              b_pend;
    int unsigned       ar_wait;
    int unsigned       r_wait;
    int unsigned       aw_wait;
    int unsigned       w_wait;
    int unsigned       b_wait;

    // fill from the byte address
    initial
    begin
        logic [7:0] a;
        for (int i = 0; i < MODEL_WORDS; i++)
        begin
            a = 8'(i * 4);
            mem[i] = {a ^ 8'h5a, ~a, a + 8'h33, a};
        end
    end

    // read side, one beat per burst
    always @(posedge aclk)
    begin
        if (!aresetn)
        begin
            arready_o <= 1'b0;
            r_o       <= '0;
            rd_pend   <= 1'b0;
            ar_wait   <= 0;
            r_wait    <= 0;
        end
        else
        begin
            if (arvalid_i && arready_o)
            begin
                arready_o <= 1'b0;
                rd_addr   <= ar_i.addr;
                rd_pend   <= 1'b1;
                r_wait    <= $urandom % 4;
            end
            else if (arvalid_i && !rd_pend && !r_o.valid)
            begin
                if (ar_wait == 0)
                    arready_o <= 1'b1;
                else
                    ar_wait <= ar_wait - 1;
            end
            if (rd_pend && !r_o.valid)
            begin
                if (r_wait == 0)
                begin
                    r_o     <= '{valid: 1'b1, data: mem[rd_addr[IDX_W+1:2]], last: 1'b1};
                    rd_pend <= 1'b0;
                end
                else
                begin
                    r_wait <= r_wait - 1;
                end
            end
            if (r_o.valid && rready_i)
            begin
                r_o     <= '0;
                ar_wait <= $urandom % 4;
            end
        end
    end

    // write side
    always @(posedge aclk)
    begin
        if (!aresetn)
        begin
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            b_pend    <= 1'b0;
            aw_wait   <= 0;
            w_wait    <= 0;
            b_wait    <= 0;
        end
        else
        begin
            if (awvalid_i && awready_o)
            begin
                awready_o <= 1'b0;
                wr_addr   <= aw_i.addr;
            end
            else if (awvalid_i)
            begin
                if (aw_wait == 0)
                    awready_o <= 1'b1;
                else
                    aw_wait <= aw_wait - 1;
            end
            if (wvalid_i && wready_o)
            begin
                wready_o <= 1'b0;
                for (int b = 0; b < STRB_W; b++)
                begin
                    if (w_i.strb[b])
                        mem[wr_addr[IDX_W+1:2]][b*8 +: 8] <= w_i.data[b*8 +: 8];
                end
                b_pend <= 1'b1;
                b_wait <= $urandom % 4;
            end
            else if (wvalid_i)
            begin
                if (w_wait == 0)
                    wready_o <= 1'b1;
                else
                    w_wait <= w_wait - 1;
            end
            if (b_pend && !bvalid_o)
            begin
                if (b_wait == 0)
                begin
                    bvalid_o <= 1'b1;
                    b_pend   <= 1'b0;
                end
                else
                begin
                    b_wait <= b_wait - 1;
                end
            end
            if (bvalid_o && bready_i)
            begin
                bvalid_o <= 1'b0;
                aw_wait  <= $urandom % 4;
                w_wait   <= $urandom % 4;
            end
        end
    end

endmodule

/* design/axi_master.sv */
`timescale 1ns/10ps

module axi_master
    import axi_master_pkg::*;
(
    input  logic              aclk,
    input  logic              aresetn,
    input  cpu_rd_req_t       inst_req_i,
    input  logic              data_ce_i,
    input  logic              data_we_i,
    input  logic [ADDR_W-1:0] data_addr_i,
    input  logic [DATA_W-1:0] data_wdata_i,
    input  logic [STRB_W-1:0] data_sel_i,
    input  logic [ID_W-1:0]   data_id_i,
    input  logic              s_arready_i,
    input  r_beat_t           s_r_i,
    input  logic              s_awready_i,
    input  logic              s_wready_i,
    input  logic              s_bvalid_i,
    output logic [DATA_W-1:0] inst_rdata_o,
    output logic              inst_stall_o,
    output logic [DATA_W-1:0] data_rdata_o,
    output logic              data_stall_o,
    output ar_req_t           s_ar_o,
    output logic              s_arvalid_o,
    output logic [LEN_W-1:0]  s_arlen_o,
    output logic [1:0]        s_arburst_o,
    output logic              s_rready_o,
    output aw_req_t           s_aw_o,
    output logic [ID_W-1:0]   s_awid_o,
    output logic [LEN_W-1:0]  s_awlen_o,
    output logic [1:0]        s_awburst_o,
    output logic              s_awvalid_o,
    output w_beat_t           s_w_o,
    output logic              s_wlast_o,
    output logic              s_wvalid_o,
    output logic              s_bready_o
);

    cpu_rd_req_t data_rd_req;
    cpu_wr_req_t data_wr_req;
    ar_req_t     inst_ar;
    ar_req_t     data_ar;
    r_beat_t     inst_r;
    r_beat_t     data_r;
    logic        inst_arvalid;
    logic        data_arvalid;
    logic        inst_rready;
    logic        data_rready;
    logic        inst_want;
    logic        data_want;
    logic        inst_owns;
    logic        data_owns;
    logic        inst_grant;
    logic        data_grant;
    logic        data_rd_stall;
    logic        wr_busy;
    logic        wr_stall;

    // data port splits on we
    assign data_rd_req = '{ce: data_ce_i && !data_we_i, addr: data_addr_i, id: data_id_i};
    assign data_wr_req = '{ce: data_ce_i && data_we_i, addr: data_addr_i,
                           wdata: data_wdata_i, sel: data_sel_i};

    assign data_stall_o = data_rd_stall | wr_stall;

    read_port_fsm #(.HOLD_RESULT(1'b1)) inst_rd_inst (
        .aclk(aclk), .aresetn(aresetn), .req_i(inst_req_i), .grant_i(inst_grant),
        .arready_i(s_arready_i), .r_i(inst_r), .other_stall_i(data_stall_o),
        .ar_o(inst_ar), .arvalid_o(inst_arvalid), .rready_o(inst_rready),
        .want_o(inst_want), .owns_o(inst_owns), .rdata_o(inst_rdata_o),
        .stall_o(inst_stall_o)
    );

    read_port_fsm #(.HOLD_RESULT(1'b0)) data_rd_inst (
        .aclk(aclk), .aresetn(aresetn), .req_i(data_rd_req), .grant_i(data_grant),
        .arready_i(s_arready_i), .r_i(data_r), .other_stall_i(wr_stall),
        .ar_o(data_ar), .arvalid_o(data_arvalid), .rready_o(data_rready),
        .want_o(data_want), .owns_o(data_owns), .rdata_o(data_rdata_o),
        .stall_o(data_rd_stall)
    );

    read_arbiter read_arbiter_inst (
        .aclk(aclk), .aresetn(aresetn), .inst_want_i(inst_want), .data_want_i(data_want),
        .write_busy_i(wr_busy), .inst_owns_i(inst_owns), .data_owns_i(data_owns),
        .inst_ar_i(inst_ar), .data_ar_i(data_ar), .inst_arvalid_i(inst_arvalid),
        .data_arvalid_i(data_arvalid), .inst_rready_i(inst_rready),
        .data_rready_i(data_rready), .s_r_i(s_r_i), .inst_grant_o(inst_grant),
        .data_grant_o(data_grant), .s_ar_o(s_ar_o), .s_arvalid_o(s_arvalid_o),
        .s_rready_o(s_rready_o), .inst_r_o(inst_r), .data_r_o(data_r)
    );

    write_port_fsm write_port_inst (
        .aclk(aclk), .aresetn(aresetn), .req_i(data_wr_req), .awready_i(s_awready_i),
        .wready_i(s_wready_i), .bvalid_i(s_bvalid_i), .aw_o(s_aw_o),
        .awvalid_o(s_awvalid_o), .w_o(s_w_o), .wvalid_o(s_wvalid_o),
        .bready_o(s_bready_o), .busy_o(wr_busy), .stall_o(wr_stall)
    );

    // single incrementing beats, fixed write id
    assign s_arlen_o   = LEN_SINGLE;
    assign s_arburst_o = BURST_INCR;
    assign s_awid_o    = WRITE_ID;
    assign s_awlen_o   = LEN_SINGLE;
    assign s_awburst_o = BURST_INCR;
    assign s_wlast_o   = 1'b1;

endmodule

/* design/write_port_fsm.sv */
`timescale 1ns/10ps

module write_port_fsm
    import axi_master_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    input  cpu_wr_req_t req_i,
    input  logic        awready_i,
    input  logic        wready_i,
    input  logic        bvalid_i,
    output aw_req_t     aw_o,
    output logic        awvalid_o,
    output w_beat_t     w_o,
    output logic        wvalid_o,
    output logic        bready_o,
    output logic        busy_o,
    output logic        stall_o
);

    wr_state_e state;
    aw_req_t   aw_q;
    w_beat_t   w_q;
    logic      aw_done;
    logic      busy;

    assign aw_done = (state == W_ADDR) && awready_i;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state <= W_FREE;
        end
        else
        begin
            case (state)
                W_FREE:
                begin
                    if (req_i.ce)
                    begin
                        state <= W_ADDR;
                    end
                end
                W_ADDR:
                begin
                    if (awready_i)
                    begin
                        state <= W_DATA;
                    end
                end
                W_DATA:
                begin
                    if (wready_i)
                    begin
                        state <= W_RESP;
                    end
                end
                default:
                begin
                    if (bvalid_i)
                    begin
                        state <= W_FREE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if ((state == W_FREE) && req_i.ce)
        begin
            aw_q <= '{addr: req_i.addr, size: SIZE_WORD};
        end
        // data word goes out after the address is taken
        if (aw_done)
        begin
            w_q <= '{data: req_i.wdata, strb: req_i.sel};
        end
    end

    assign awvalid_o = (state == W_ADDR);
    assign wvalid_o  = (state == W_DATA);
    assign bready_o  = (state == W_DATA) || (state == W_RESP);
    assign aw_o      = awvalid_o ? aw_q : '0;
    assign w_o       = wvalid_o ? w_q : '0;

    // busy until the B handshake, released in that cycle
    always_comb
    begin
        case (state)
            W_FREE:
            begin
                busy = req_i.ce;
            end
            W_RESP:
            begin
                busy = !bvalid_i;
            end
            default:
            begin
                busy = 1'b1;
            end
        endcase
    end

    assign busy_o  = busy;
    assign stall_o = busy;

endmodule

/* design/read_arbiter.sv */
`timescale 1ns/10ps

module read_arbiter
    import axi_master_pkg::*;
(
    input  logic    aclk,
    input  logic    aresetn,
    input  logic    inst_want_i,
    input  logic    data_want_i,
    input  logic    write_busy_i,
    input  logic    inst_owns_i,
    input  logic    data_owns_i,
    input  ar_req_t inst_ar_i,
    input  ar_req_t data_ar_i,
    input  logic    inst_arvalid_i,
    input  logic    data_arvalid_i,
    input  logic    inst_rready_i,
    input  logic    data_rready_i,
    input  r_beat_t s_r_i,
    output logic    inst_grant_o,
    output logic    data_grant_o,
    output ar_req_t s_ar_o,
    output logic    s_arvalid_o,
    output logic    s_rready_o,
    output r_beat_t inst_r_o,
    output r_beat_t data_r_o
);

    logic chan_busy;
    logic chan_free;
    logic rd_last;

    // reads are serialized, and none starts while a write is pending
    assign chan_free = !chan_busy && !write_busy_i;
    assign rd_last   = s_r_i.valid && s_r_i.last && s_rready_o;

    // data port wins ties
    assign data_grant_o = chan_free && data_want_i;
    assign inst_grant_o = chan_free && inst_want_i && !data_want_i;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            chan_busy <= 1'b0;
        end
        else if (inst_grant_o || data_grant_o)
        begin
            chan_busy <= 1'b1;
        end
        else if (rd_last)
        begin
            chan_busy <= 1'b0;
        end
    end

    // idle ports drive zeros
    assign s_ar_o      = ar_req_t'(inst_ar_i | data_ar_i);
    assign s_arvalid_o = inst_arvalid_i | data_arvalid_i;
    assign s_rready_o  = inst_rready_i | data_rready_i;

    // beat steering by owner
    assign inst_r_o = inst_owns_i ? s_r_i : '0;
    assign data_r_o = data_owns_i ? s_r_i : '0;

endmodule

/* design/read_port_fsm.sv */
`timescale 1ns/10ps

module read_port_fsm
    import axi_master_pkg::*;
#(
    parameter bit HOLD_RESULT = 1'b0
)
(
    input  logic              aclk,
    input  logic              aresetn,
    input  cpu_rd_req_t       req_i,
    input  logic              grant_i,
    input  logic              arready_i,
    input  r_beat_t           r_i,
    input  logic              other_stall_i,
    output ar_req_t           ar_o,
    output logic              arvalid_o,
    output logic              rready_o,
    output logic              want_o,
    output logic              owns_o,
    output logic [DATA_W-1:0] rdata_o,
    output logic              stall_o
);

    rd_state_e         state;
    ar_req_t           ar_q;
    logic [DATA_W-1:0] hold_buf;
    logic              start;
    logic              beat_done;

    assign start     = (state == R_FREE) && req_i.ce && grant_i;
    // one beat per read, so rlast closes the transfer
    assign beat_done = (state == R_DATA) && r_i.valid && r_i.last;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state <= R_FREE;
        end
        else
        begin
            case (state)
                R_FREE:
                begin
                    if (start)
                    begin
                        state <= R_ADDR;
                    end
                end
                R_ADDR:
                begin
                    if (arready_i)
                    begin
                        state <= R_DATA;
                    end
                end
                R_DATA:
                begin
                    if (beat_done)
                    begin
                        // keep the word while the other port is still stalled
                        if (HOLD_RESULT && other_stall_i)
                        begin
                            state <= R_HOLD;
                        end
                        else
                        begin
                            state <= R_FREE;
                        end
                    end
                end
                default:
                begin
                    if (!other_stall_i)
                    begin
                        state <= R_FREE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (start)
        begin
            ar_q <= '{id: req_i.id, addr: req_i.addr, size: SIZE_WORD};
        end
        if (beat_done)
        begin
            hold_buf <= r_i.data;
        end
    end

    assign want_o    = (state == R_FREE) && req_i.ce;
    assign owns_o    = (state == R_ADDR) || (state == R_DATA);
    assign arvalid_o = (state == R_ADDR);
    assign rready_o  = (state == R_DATA);
    // zeros when idle so the arbiter can OR both ports
    assign ar_o      = arvalid_o ? ar_q : '0;

    always_comb
    begin
        case (state)
            R_FREE:
            begin
                stall_o = req_i.ce;
                rdata_o = '0;
            end
            R_ADDR:
            begin
                stall_o = 1'b1;
                rdata_o = '0;
            end
            R_DATA:
            begin
                stall_o = !beat_done;
                rdata_o = beat_done ? r_i.data : '0;
            end
            default:
            begin
                stall_o = 1'b0;
                rdata_o = hold_buf;
            end
        endcase
    end

endmodule

/* design/axi_master_pkg.sv */
package axi_master_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W   = 4;
    localparam int STRB_W = 4;
    localparam int LEN_W  = 4;

    // 4-byte beats, one beat per burst
    localparam logic [2:0]       SIZE_WORD  = 3'b010;
    localparam logic [1:0]       BURST_INCR = 2'b01;
    localparam logic [LEN_W-1:0] LEN_SINGLE = '0;

    localparam logic [ID_W-1:0] WRITE_ID = 4'd1;

    // slave model depth in words
    localparam int MODEL_WORDS = 64;

    typedef struct packed {
        logic              ce;
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
    } cpu_rd_req_t;

    typedef struct packed {
        logic              ce;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] sel;
    } cpu_wr_req_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [2:0]        size;
    } ar_req_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
        logic              last;
    } r_beat_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [2:0]        size;
    } aw_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } w_beat_t;

    typedef enum logic [1:0] {
        R_FREE,
        R_ADDR,
        R_DATA,
        R_HOLD
    } rd_state_e;

    typedef enum logic [1:0] {
        W_FREE,
        W_ADDR,
        W_DATA,
        W_RESP
    } wr_state_e;

endpackage
